//--- Makefile
TOP = shared_fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/shared_fifo_tb.sv
// Testbench for the shared multi-FIFO that checks random pushes and pops against a queue per FIFO
`default_nettype none

module shared_fifo_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import shared_fifo_geom_pkg::*;
  import shared_fifo_arb_pkg::*;

  localparam int NUM_FIFOS = DEFAULT_NUM_FIFOS;
  localparam int DEPTH     = DEFAULT_DEPTH;
  localparam int WIDTH     = DEFAULT_WIDTH;

  // Cycle budgets of the individual tests
  localparam int ORDER_CYCLES    = 400;
  localparam int DRAIN_LIMIT     = 100;
  localparam int FILL_LIMIT      = 100;
  localparam int LIVENESS_CYCLES = 200;
  // Push back-pressure must hold this long before storage counts as settled
  localparam int SETTLE_CYCLES   = 2 * NUM_FIFOS + 4;
  localparam int TEST_CYCLES     = 3 + 1 + ORDER_CYCLES + 2 * DRAIN_LIMIT + FILL_LIMIT +
                                   LIVENESS_CYCLES;
  localparam int TIMEOUT_CYCLES  = 2 * TEST_CYCLES + 100;

  logic                        clk;
  logic                        arst_n;
  logic                        push_valid;
  logic                        push_ready;
  fifo_idx_t                   push_fifo;
  logic [WIDTH-1:0]            push_data;
  logic [NUM_FIFOS-1:0]        pop_valid;
  logic [NUM_FIFOS-1:0]        pop_ready;
  logic [NUM_FIFOS-1:0][WIDTH-1:0] pop_data;
  logic [NUM_FIFOS-1:0]        pop_empty;

  // Reference model with one queue of payloads per logical FIFO
  logic [WIDTH-1:0] model_q [NUM_FIFOS][$];
  int               starve_cnt [NUM_FIFOS];

  logic [31:0]          lfsr_q;
  logic                 push_enable;
  logic                 push_always;
  logic                 pop_random;
  logic [NUM_FIFOS-1:0] pop_fixed;

  string cur_test;
  int    err_cnt;
  int    test_err_start;
  int    test_cnt;
  int    failed_tests;
  int    cycle_cnt;

  shared_fifo_top #(
    .NUM_FIFOS(NUM_FIFOS),
    .DEPTH    (DEPTH),
    .WIDTH    (WIDTH)
  ) shared_fifo_top_i (
    .clk,
    .arst_n,
    .push_valid,
    .push_ready,
    .push_fifo,
    .push_data,
    .pop_valid,
    .pop_ready,
    .pop_data,
    .pop_empty
  );

  always #10 clk = ~clk;

  // Hard stop in case a wait loop never ends
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int total_items();
    int n;
    n = 0;
    for (int i = 0; i < NUM_FIFOS; i++) begin
      n += model_q[i].size();
    end
    return n;
  endfunction

  // With pops stalled each staging buffer ends up holding up to two items of its FIFO
  function automatic int staged_items();
    int n;
    n = 0;
    for (int i = 0; i < NUM_FIFOS; i++) begin
      n += (model_q[i].size() < 2) ? model_q[i].size() : 2;
    end
    return n;
  endfunction

  task automatic report_mismatch(string what, logic [31:0] exp_val, logic [31:0] act_val);
    $display("mismatch in %s: %s expected %0h actual %0h", cur_test, what, exp_val, act_val);
    err_cnt++;
  endtask

  task automatic begin_test(string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    int errs;
    errs = err_cnt - test_err_start;
    test_cnt++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %-14s finished with %0d errors", cur_test, errs);
  endtask

  // A pop must return the oldest payload still held for that FIFO
  task automatic check_pop(int f);
    logic [WIDTH-1:0] exp_val;
    if (model_q[f].size() == 0) begin
      assert (model_q[f].size() != 0) else begin
        $display("error in %s: FIFO %0d popped an item that was never pushed", cur_test, f);
        err_cnt++;
      end
    end else begin
      exp_val = model_q[f].pop_front();
      assert (pop_data[f] == exp_val) else begin
        report_mismatch($sformatf("pop_data[%0d]", f), 32'(exp_val), 32'(pop_data[f]));
      end
    end
  endtask

  // Sample the transfers of one clock edge and then drive the inputs for the next cycle
  task automatic step_cycle();
    @(posedge clk);
    for (int i = 0; i < NUM_FIFOS; i++) begin
      // Consecutive cycles where FIFO i holds data, is ready and offers nothing
      if (model_q[i].size() > 0 && pop_ready[i] && !pop_valid[i]) begin
        starve_cnt[i]++;
      end else begin
        starve_cnt[i] = 0;
      end
      assert (starve_cnt[i] <= NUM_FIFOS + 3) else begin
        $display("error in %s: FIFO %0d starved, no pop_valid for %0d cycles",
                 cur_test, i, starve_cnt[i]);
        err_cnt++;
        starve_cnt[i] = 0;
      end
      // The FIFO reports empty exactly when the model holds nothing for it
      assert (pop_empty[i] == (model_q[i].size() == 0)) else begin
        report_mismatch($sformatf("pop_empty[%0d]", i), 32'(model_q[i].size() == 0),
                        32'(pop_empty[i]));
      end
      if (pop_valid[i] && pop_ready[i]) begin
        check_pop(i);
      end
    end
    if (push_valid && push_ready) begin
      model_q[int'(push_fifo)].push_back(push_data);
    end
    // A pending push keeps its FIFO and payload until it transfers
    if (!push_valid || push_ready) begin
      if (push_enable && (push_always || random_bits(2) != 0)) begin
        push_valid <= 1'b1;
        push_fifo  <= fifo_idx_t'(random_bits(2) % NUM_FIFOS);
        push_data  <= WIDTH'(random_bits(WIDTH));
      end else begin
        push_valid <= 1'b0;
      end
    end
    if (pop_random) begin
      pop_ready <= NUM_FIFOS'(random_bits(NUM_FIFOS));
    end else begin
      pop_ready <= pop_fixed;
    end
  endtask

  task automatic reset_state_test();
    begin_test("reset_state");
    step_cycle();
    assert (pop_valid == '0) else report_mismatch("pop_valid", 32'h0, 32'(pop_valid));
    assert (&pop_empty) else report_mismatch("pop_empty", 32'hf, 32'(pop_empty));
    assert (push_ready) else report_mismatch("push_ready", 32'h1, 32'(push_ready));
    end_test();
  endtask

  task automatic order_test();
    begin_test("order");
    push_enable = 1'b1;
    pop_random  = 1'b1;
    repeat (ORDER_CYCLES) begin
      step_cycle();
    end
    end_test();
  endtask

  // Stops pushing, pops everything and waits until the design reports all FIFOs empty
  task automatic drain_test(string name);
    int   cycles;
    logic drained;
    begin_test(name);
    push_enable = 1'b0;
    pop_random  = 1'b0;
    pop_fixed   = '1;
    cycles      = 0;
    drained     = 1'b0;
    while (!drained && cycles < DRAIN_LIMIT) begin
      step_cycle();
      cycles++;
      drained = !push_valid && total_items() == 0 && (&pop_empty) && push_ready;
    end
    assert (drained) else begin
      $display("error in %s: FIFOs did not drain within %0d cycles", cur_test, DRAIN_LIMIT);
      err_cnt++;
    end
    assert (pop_valid == '0) else report_mismatch("pop_valid", 32'h0, 32'(pop_valid));
    end_test();
  endtask

  // Pushes every cycle with all pops stalled until push_ready stays low
  task automatic full_storage_test();
    int cycles;
    int low_run;
    int total;
    int staged;
    begin_test("full_storage");
    pop_random  = 1'b0;
    pop_fixed   = '0;
    push_enable = 1'b1;
    push_always = 1'b1;
    cycles      = 0;
    low_run     = 0;
    while (low_run < SETTLE_CYCLES && cycles < FILL_LIMIT) begin
      step_cycle();
      cycles++;
      low_run = push_ready ? 0 : low_run + 1;
    end
    total  = total_items();
    staged = staged_items();
    assert (low_run >= SETTLE_CYCLES) else begin
      $display("error in %s: push_ready did not stay low with all pops stalled", cur_test);
      err_cnt++;
    end
    // Every entry in use belongs to an item still waiting in a head queue
    assert (total - staged == DEPTH) else begin
      report_mismatch("entries in use", 32'(DEPTH), 32'(total - staged));
    end
    assert (total >= DEPTH && total <= DEPTH + 2 * NUM_FIFOS) else begin
      $display("error in %s: %0d items accepted, outside %0d to %0d",
               cur_test, total, DEPTH, DEPTH + 2 * NUM_FIFOS);
      err_cnt++;
    end
    push_enable = 1'b0;
    push_always = 1'b0;
    end_test();
  endtask

  // Steady pushes with every pop port ready keep the starvation monitor armed
  task automatic liveness_test();
    begin_test("liveness");
    push_enable = 1'b1;
    pop_random  = 1'b0;
    pop_fixed   = '1;
    repeat (LIVENESS_CYCLES) begin
      step_cycle();
    end
    end_test();
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    push_valid   = 1'b0;
    push_fifo    = '0;
    push_data    = '0;
    pop_ready    = '0;
    lfsr_q       = 32'hf45b;
    push_enable  = 1'b0;
    push_always  = 1'b0;
    pop_random   = 1'b0;
    pop_fixed    = '0;
    err_cnt      = 0;
    test_cnt     = 0;
    failed_tests = 0;
    cycle_cnt    = 0;
    for (int i = 0; i < NUM_FIFOS; i++) begin
      starve_cnt[i] = 0;
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    reset_state_test();
    order_test();
    drain_test("isolation");
    full_storage_test();
    drain_test("drain");
    liveness_test();

    $display("summary: %0d tests, %0d failed, %0d errors", test_cnt, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/shared_fifo_geom_pkg.sv
hw/shared_fifo_arb_pkg.sv
hw/shared_fifo_freelist.sv
hw/shared_fifo_push_ctrl.sv
hw/shared_fifo_head_queue.sv
hw/shared_fifo_data_ram.sv
hw/shared_fifo_pop_ctrl.sv
hw/shared_fifo_top.sv
dv/shared_fifo_tb.sv

//--- hw/shared_fifo_arb_pkg.sv
// Shared FIFO arbitration: FIFO index type, one-hot conversions and round-robin stepping
`default_nettype none

package shared_fifo_arb_pkg;

  // Largest FIFO count the index type can address
  parameter int MAX_FIFOS = 16;

  typedef logic [3:0] fifo_idx_t;

  // Expand a FIFO index into a one-hot strobe vector
  function automatic logic [MAX_FIFOS-1:0] idx_to_onehot(fifo_idx_t idx);
    logic [MAX_FIFOS-1:0] oh;
    oh = '0;
    oh[idx] = 1'b1;
    return oh;
  endfunction

  // Encode a one-hot (or all-zero) grant back into an index
  function automatic fifo_idx_t onehot_to_idx(logic [MAX_FIFOS-1:0] oh);
    fifo_idx_t idx;
    idx = '0;
    for (int i = 0; i < MAX_FIFOS; i++) begin
      if (oh[i]) begin
        idx = idx | fifo_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // The FIFO after the winner gets first priority next time
  function automatic fifo_idx_t rr_next(fifo_idx_t grant, int num_fifos);
    return (int'(grant) == num_fifos - 1) ? fifo_idx_t'(0) : fifo_idx_t'(grant + 1'b1);
  endfunction

endpackage

`default_nettype wire

//--- hw/shared_fifo_data_ram.sv
// Shared data RAM: one write port and one read port with a registered one-cycle read
`default_nettype none

module shared_fifo_data_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 8
) (
  input  logic                                                clk,
  input  logic                                                ram_wr_en,
  input  logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] ram_wr_addr,
  input  logic [WIDTH-1:0]                                    ram_wr_data,
  input  logic                                                ram_rd_en,
  input  logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] ram_rd_addr,
  output logic [WIDTH-1:0]                                    ram_rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // A read of an entry never overlaps a write of it, since entries are
  // only reused after their read has issued
  always_ff @(posedge clk) begin
    if (ram_wr_en) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
    if (ram_rd_en) begin
      ram_rd_data <= mem[ram_rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hw/shared_fifo_freelist.sv
// Freelist for the shared RAM: offers the lowest free entry and takes back released entries
`default_nettype none

module shared_fifo_freelist #(
  parameter int DEPTH = 16
) (
  input  logic                                                clk,
  input  logic                                                arst_n,
  input  logic                                                alloc_take,
  output logic                                                alloc_valid,
  output logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] alloc_entry,
  input  logic                                                dealloc_valid,
  input  logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] dealloc_entry
);
  import shared_fifo_geom_pkg::*;

  localparam int AW = addr_width(DEPTH);
  localparam int CW = count_width(DEPTH);

  // One bit per RAM entry, set while the entry is free
  logic [DEPTH-1:0] free_q;
  // Entries currently handed out, whether still queued or being read
  logic [CW-1:0]    used_q;

  assign alloc_valid = |free_q;

  // Priority encoder that favours the lowest free entry
  always_comb begin
    alloc_entry = '0;
    for (int e = DEPTH - 1; e >= 0; e--) begin
      if (free_q[e]) begin
        alloc_entry = AW'(e);
      end
    end
  end

  // Take and release land on the same edge and never touch the same entry
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      free_q <= '1;
      used_q <= '0;
    end else begin
      if (alloc_take) begin
        free_q[alloc_entry] <= 1'b0;
      end
      if (dealloc_valid) begin
        free_q[dealloc_entry] <= 1'b1;
      end
      used_q <= used_q + CW'(alloc_take) - CW'(dealloc_valid);
    end
  end

  // A released entry has to be one that was handed out earlier
  dealloc_allocated_a: assert property (@(posedge clk) disable iff (!arst_n)
    dealloc_valid |-> !free_q[dealloc_entry]);

  // The push side may only take what is offered
  take_offered_a: assert property (@(posedge clk) disable iff (!arst_n)
    alloc_take |-> alloc_valid);

  // Bitmap and running count agree on when the storage is exhausted
  count_matches_map_a: assert property (@(posedge clk) disable iff (!arst_n)
    alloc_valid != (used_q == CW'(DEPTH)));

endmodule

`default_nettype wire

//--- hw/shared_fifo_geom_pkg.sv
// Shared FIFO geometry: default sizes and derived widths for the common entry storage
`default_nettype none

package shared_fifo_geom_pkg;

  // Number of logical FIFOs sharing the storage
  parameter int DEFAULT_NUM_FIFOS = 4;
  // Entries in the shared data RAM, which is also the length of each head queue
  parameter int DEFAULT_DEPTH = 16;
  // Payload width of one entry
  parameter int DEFAULT_WIDTH = 8;

  // Width of an entry number, never below one bit so a single-entry RAM still has an address
  function automatic int addr_width(int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

  // Width of a count that must be able to hold the full depth
  function automatic int count_width(int depth);
    return $clog2(depth + 1);
  endfunction

endpackage

`default_nettype wire

//--- hw/shared_fifo_head_queue.sv
// Head queue: entry numbers of one logical FIFO kept in push order
`default_nettype none

module shared_fifo_head_queue #(
  parameter int DEPTH = 16
) (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  logic                                                 enq_valid,
  input  logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0]  enq_entry,
  output logic                                                 head_valid,
  input  logic                                                 head_ready,
  output logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0]  head,
  output logic [shared_fifo_geom_pkg::count_width(DEPTH)-1:0] ram_items
);
  import shared_fifo_geom_pkg::*;

  localparam int AW = addr_width(DEPTH);
  localparam int CW = count_width(DEPTH);

  // Entry numbers only, so the queue is tiny next to the data RAM
  logic [AW-1:0] slot_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          deq;

  assign deq = head_valid && head_ready;

  assign head_valid = (count_q != '0);
  assign head       = slot_q[rd_ptr_q];
  assign ram_items  = count_q;

  // Pointers wrap at DEPTH so odd sizes work too
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (enq_valid) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (deq) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CW'(enq_valid) - CW'(deq);
    end
  end

  always_ff @(posedge clk) begin
    if (enq_valid) begin
      slot_q[wr_ptr_q] <= enq_entry;
    end
  end

  // Never full in practice since the freelist runs dry first
  no_overflow_a: assert property (@(posedge clk) disable iff (!arst_n)
    enq_valid |-> (count_q != CW'(DEPTH)));

  // The pop side only grants a FIFO that offers a head
  no_grant_when_empty_a: assert property (@(posedge clk) disable iff (!arst_n)
    head_ready |-> head_valid);

endmodule

`default_nettype wire

//--- hw/shared_fifo_pop_ctrl.sv
// Pop controller that arbitrates RAM reads round-robin, frees entries and fills staging buffers
`default_nettype none

module shared_fifo_pop_ctrl #(
  parameter int NUM_FIFOS = 4,
  parameter int DEPTH     = 16,
  parameter int WIDTH     = 8
) (
  input  logic                                                                 clk,
  input  logic                                                                 arst_n,
  input  logic [NUM_FIFOS-1:0]                                                 head_valid,
  output logic [NUM_FIFOS-1:0]                                                 head_ready,
  input  logic [NUM_FIFOS-1:0][shared_fifo_geom_pkg::addr_width(DEPTH)-1:0]  head,
  input  logic [NUM_FIFOS-1:0][shared_fifo_geom_pkg::count_width(DEPTH)-1:0] ram_items,
  output logic                                                                 ram_rd_en,
  output logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0]                  ram_rd_addr,
  input  logic [WIDTH-1:0]                                                     ram_rd_data,
  output logic [NUM_FIFOS-1:0]                                                 pop_valid,
  input  logic [NUM_FIFOS-1:0]                                                 pop_ready,
  output logic [NUM_FIFOS-1:0][WIDTH-1:0]                                      pop_data,
  output logic [NUM_FIFOS-1:0]                                                 pop_empty,
  output logic                                                                 dealloc_valid,
  output logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0]                  dealloc_entry
);
  import shared_fifo_arb_pkg::*;

  // FIFOs that have a head and room for one more item in staging
  logic [NUM_FIFOS-1:0] eligible;
  logic [NUM_FIFOS-1:0] grant;
  fifo_idx_t            grant_idx;
  // First FIFO examined in the next arbitration round
  fifo_idx_t            rr_ptr_q;
  // A read issued last cycle returns data now and is tagged with its FIFO
  logic                 rd_pending_q;
  fifo_idx_t            rd_fifo_q;

  // Scan from the round-robin pointer and take the first eligible FIFO
  always_comb begin
    int   idx;
    logic found;
    grant = '0;
    found = 1'b0;
    for (int k = 0; k < NUM_FIFOS; k++) begin
      idx = int'(rr_ptr_q) + k;
      if (idx >= NUM_FIFOS) begin
        idx = idx - NUM_FIFOS;
      end
      if (!found && eligible[idx]) begin
        grant[idx] = 1'b1;
        found      = 1'b1;
      end
    end
  end

  assign grant_idx  = onehot_to_idx(MAX_FIFOS'(grant));
  assign head_ready = grant;

  // The read and the release of the entry happen together, as the data
  // is captured by the RAM output register on this same edge
  assign ram_rd_en     = |grant;
  assign ram_rd_addr   = head[grant_idx];
  assign dealloc_valid = ram_rd_en;
  assign dealloc_entry = ram_rd_addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_ptr_q     <= '0;
      rd_pending_q <= 1'b0;
      rd_fifo_q    <= '0;
    end else begin
      rd_pending_q <= ram_rd_en;
      if (ram_rd_en) begin
        rr_ptr_q  <= rr_next(grant_idx, NUM_FIFOS);
        rd_fifo_q <= grant_idx;
      end
    end
  end

  for (genvar i = 0; i < NUM_FIFOS; i++) begin : gen_stage
    // Two-slot circular buffer in front of each pop port
    logic [1:0][WIDTH-1:0] stg_mem;
    logic                  stg_wr_ptr;
    logic                  stg_rd_ptr;
    logic [1:0]            stg_cnt;
    logic                  rd_return;
    logic                  stg_pop;

    assign rd_return = rd_pending_q && (rd_fifo_q == fifo_idx_t'(i));
    assign stg_pop   = pop_valid[i] && pop_ready[i];

    // A read in flight already owns a slot and counts against the space
    assign eligible[i] = head_valid[i] && ((stg_cnt + {1'b0, rd_return}) < 2'd2);

    assign pop_valid[i] = (stg_cnt != 2'd0);
    assign pop_data[i]  = stg_mem[stg_rd_ptr];
    assign pop_empty[i] = (ram_items[i] == '0) && (stg_cnt == 2'd0) && !rd_return;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        stg_wr_ptr <= 1'b0;
        stg_rd_ptr <= 1'b0;
        stg_cnt    <= 2'd0;
      end else begin
        if (rd_return) begin
          stg_wr_ptr <= ~stg_wr_ptr;
        end
        if (stg_pop) begin
          stg_rd_ptr <= ~stg_rd_ptr;
        end
        stg_cnt <= stg_cnt + {1'b0, rd_return} - {1'b0, stg_pop};
      end
    end

    always_ff @(posedge clk) begin
      if (rd_return) begin
        stg_mem[stg_wr_ptr] <= ram_rd_data;
      end
    end

    // Returning data always finds a free slot because of the eligibility rule a cycle earlier
    stage_no_overflow_a: assert property (@(posedge clk) disable iff (!arst_n)
      rd_return |-> (stg_cnt < 2'd2));

    // An offered item and its payload hold until the consumer takes it
    pop_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
      pop_valid[i] && !pop_ready[i] |=> pop_valid[i] && $stable(pop_data[i]));
  end

  // With a single read port at most one FIFO is granted per cycle
  one_grant_a: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(head_ready));

endmodule

`default_nettype wire

//--- hw/shared_fifo_push_ctrl.sv
// Push controller: accepts items, allocates a RAM entry and appends it to the target head queue
`default_nettype none

module shared_fifo_push_ctrl #(
  parameter int NUM_FIFOS = 4,
  parameter int DEPTH     = 16,
  parameter int WIDTH     = 8
) (
  input  logic                                                clk,
  input  logic                                                arst_n,
  input  logic                                                push_valid,
  output logic                                                push_ready,
  input  shared_fifo_arb_pkg::fifo_idx_t                      push_fifo,
  input  logic [WIDTH-1:0]                                    push_data,
  input  logic                                                alloc_valid,
  input  logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] alloc_entry,
  output logic                                                alloc_take,
  output logic [NUM_FIFOS-1:0]                                enq_valid,
  output logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] enq_entry,
  output logic                                                ram_wr_en,
  output logic [shared_fifo_geom_pkg::addr_width(DEPTH)-1:0] ram_wr_addr,
  output logic [WIDTH-1:0]                                    ram_wr_data
);
  import shared_fifo_arb_pkg::*;

  logic                 push_xfer;
  logic [MAX_FIFOS-1:0] fifo_onehot;

  // Ready only while the freelist has an entry to give
  assign push_ready = alloc_valid;
  assign push_xfer  = push_valid && push_ready;

  assign alloc_take = push_xfer;

  // The item goes to the RAM and its entry number to the queue on the same edge
  assign ram_wr_en   = push_xfer;
  assign ram_wr_addr = alloc_entry;
  assign ram_wr_data = push_data;

  assign fifo_onehot = idx_to_onehot(push_fifo);
  assign enq_valid   = push_xfer ? fifo_onehot[NUM_FIFOS-1:0] : '0;
  assign enq_entry   = alloc_entry;

  // Items for a FIFO that does not exist would be lost with their entry
  push_fifo_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    push_valid |-> (int'(push_fifo) < NUM_FIFOS));

endmodule

`default_nettype wire

//--- hw/shared_fifo_top.sv
// Shared multi-FIFO top: logical FIFOs kept in one data RAM behind a single push port
`default_nettype none

module shared_fifo_top #(
  parameter int NUM_FIFOS = shared_fifo_geom_pkg::DEFAULT_NUM_FIFOS,
  parameter int DEPTH     = shared_fifo_geom_pkg::DEFAULT_DEPTH,
  parameter int WIDTH     = shared_fifo_geom_pkg::DEFAULT_WIDTH
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           push_valid,
  output logic                           push_ready,
  input  shared_fifo_arb_pkg::fifo_idx_t push_fifo,
  input  logic [WIDTH-1:0]               push_data,
  output logic [NUM_FIFOS-1:0]           pop_valid,
  input  logic [NUM_FIFOS-1:0]           pop_ready,
  output logic [NUM_FIFOS-1:0][WIDTH-1:0] pop_data,
  output logic [NUM_FIFOS-1:0]           pop_empty
);
  import shared_fifo_geom_pkg::*;

  localparam int AW = addr_width(DEPTH);
  localparam int CW = count_width(DEPTH);

  // Freelist handshake on both sides
  logic          alloc_valid;
  logic          alloc_take;
  logic [AW-1:0] alloc_entry;
  logic          dealloc_valid;
  logic [AW-1:0] dealloc_entry;

  // Head queue traffic
  logic [NUM_FIFOS-1:0]         enq_valid;
  logic [AW-1:0]                enq_entry;
  logic [NUM_FIFOS-1:0]         head_valid;
  logic [NUM_FIFOS-1:0]         head_ready;
  logic [NUM_FIFOS-1:0][AW-1:0] head;
  logic [NUM_FIFOS-1:0][CW-1:0] ram_items;

  // Data RAM ports
  logic             ram_wr_en;
  logic [AW-1:0]    ram_wr_addr;
  logic [WIDTH-1:0] ram_wr_data;
  logic             ram_rd_en;
  logic [AW-1:0]    ram_rd_addr;
  logic [WIDTH-1:0] ram_rd_data;

  shared_fifo_freelist #(
    .DEPTH(DEPTH)
  ) freelist_i (
    .clk,
    .arst_n,
    .alloc_take,
    .alloc_valid,
    .alloc_entry,
    .dealloc_valid,
    .dealloc_entry
  );

  shared_fifo_push_ctrl #(
    .NUM_FIFOS(NUM_FIFOS),
    .DEPTH    (DEPTH),
    .WIDTH    (WIDTH)
  ) push_ctrl_i (
    .clk,
    .arst_n,
    .push_valid,
    .push_ready,
    .push_fifo,
    .push_data,
    .alloc_valid,
    .alloc_entry,
    .alloc_take,
    .enq_valid,
    .enq_entry,
    .ram_wr_en,
    .ram_wr_addr,
    .ram_wr_data
  );

  // Every queue sees the same entry number and only the strobed one keeps it
  for (genvar i = 0; i < NUM_FIFOS; i++) begin : gen_head_queue
    shared_fifo_head_queue #(
      .DEPTH(DEPTH)
    ) head_queue_i (
      .clk,
      .arst_n,
      .enq_valid (enq_valid[i]),
      .enq_entry (enq_entry),
      .head_valid(head_valid[i]),
      .head_ready(head_ready[i]),
      .head      (head[i]),
      .ram_items (ram_items[i])
    );
  end

  shared_fifo_data_ram #(
    .DEPTH(DEPTH),
    .WIDTH(WIDTH)
  ) data_ram_i (
    .clk,
    .ram_wr_en,
    .ram_wr_addr,
    .ram_wr_data,
    .ram_rd_en,
    .ram_rd_addr,
    .ram_rd_data
  );

  shared_fifo_pop_ctrl #(
    .NUM_FIFOS(NUM_FIFOS),
    .DEPTH    (DEPTH),
    .WIDTH    (WIDTH)
  ) pop_ctrl_i (
    .clk,
    .arst_n,
    .head_valid,
    .head_ready,
    .head,
    .ram_items,
    .ram_rd_en,
    .ram_rd_addr,
    .ram_rd_data,
    .pop_valid,
    .pop_ready,
    .pop_data,
    .pop_empty,
    .dealloc_valid,
    .dealloc_entry
  );

endmodule

`default_nettype wire
